/* Bender.yml */
package:
  name: scroll_layer

sources:
  - scroll_pkg.sv
  - scroll_tilemap.sv
  - scroll_fetch_ctrl.sv
  - scroll_pixel_shifter.sv
  - scroll_palette.sv
  - scroll_layer.sv
  - target: test
    files:
      - scroll_checker.sv
      - scroll_tb.sv

/* scroll_checker.sv */
// Scroll layer checker
// Keeps reference copies of the tile map, graphics ROM and palette,
// taken from the DUT's input ports, and checks CPU map reads and the
// pixel stream against them. Errors and checks are counted
module scroll_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,

    // CPU port
    input  scroll_pkg::cpu_addr_t cpu_addr,
    input  scroll_pkg::byte_t     cpu_dout,
    input  logic                  cpu_rnw,
    input  logic                  map_cs,
    input  scroll_pkg::byte_t     map_dout,

    // Beam and scroll
    input  scroll_pkg::hpos_t     hpos,
    input  scroll_pkg::hpos_t     hdump,
    input  scroll_pkg::vpos_t     vdump,
    input  logic                  flip,

    // Palette programming and ROM loading
    input  logic                  prog_en,
    input  scroll_pkg::pal_addr_t prog_addr,
    input  scroll_pkg::nibble_t   prog_data,
    input  logic                  rom_fill_en,
    input  scroll_pkg::rom_addr_t rom_fill_addr,
    input  scroll_pkg::rom_row_t  rom_fill_data,

    input  scroll_pkg::nibble_t   pxl,

    output int                    err_count,
    output int                    read_checks,
    output int                    pxl_checks
);

    // Pixels into a line before the pipeline holds only this line's tiles
    localparam scroll_pkg::hpos_t WARMUP = 9'd24;
    // heff to pxl delay: map at phase 7, ROM at 0, load at 4, then palette register
    localparam scroll_pkg::hpos_t DELAY_NORMAL = 9'd13;
    localparam scroll_pkg::hpos_t DELAY_FLIP   = 9'd12;   // Phases count down under flip

    scroll_pkg::byte_t    map_ref [4096];   // Code bank low, attribute bank high
    scroll_pkg::rom_row_t rom_ref [8192];
    scroll_pkg::nibble_t  pal_ref [256];

    logic                 rd_pend = 1'b0;
    scroll_pkg::byte_t    rd_exp;
    logic                 px_pend = 1'b0;
    scroll_pkg::nibble_t  px_exp;
    scroll_pkg::hpos_t    px_col;

    // Colour that should leave the palette on the pixel strobe seen with these inputs
    function automatic scroll_pkg::nibble_t expected_pixel(
        input scroll_pkg::hpos_t h,
        input scroll_pkg::hpos_t s,
        input scroll_pkg::vpos_t v,
        input logic              f
    );
        scroll_pkg::hpos_t      q;          // Fetch column of the pixel now shown
        logic [5:0]             col;
        scroll_pkg::vpos_t      veff;
        scroll_pkg::map_addr_t  idx;
        scroll_pkg::byte_t      code;
        scroll_pkg::tile_attr_t attr;
        logic [2:0]             row;
        logic [2:0]             nib;        // Nibble index counted from bits 31:28
        scroll_pkg::rom_row_t   word;
        q    = h + s + scroll_pkg::FETCH_LEAD - (f ? DELAY_FLIP : DELAY_NORMAL);
        col  = f ? {q[8], ~q[7:3]} : q[8:3];   // Flip mirrors the low 8 bits only
        veff = v ^ {8{f}};
        idx  = {veff[7:3], col};
        code = map_ref[{1'b0, idx}];
        attr = scroll_pkg::tile_attr_t'(map_ref[{1'b1, idx}]);
        row  = veff[2:0] ^ {3{attr.vflip}};
        word = rom_ref[{attr.code_hi, code, row}];
        nib  = q[2:0] ^ {3{attr.hflip ^ f}};   // Screen flip mirrors each tile too
        return pal_ref[{attr.pal, word[(7 - nib) * 4 +: 4]}];
    endfunction

    initial begin
        err_count   = 0;
        read_checks = 0;
        pxl_checks  = 0;
    end

    always @(posedge clk) begin
        // Reference copies follow the input ports
        if (rom_fill_en)
            rom_ref[rom_fill_addr] <= rom_fill_data;
        if (prog_en)
            pal_ref[prog_addr] <= prog_data;
        if (!rst && map_cs && !cpu_rnw)
            map_ref[cpu_addr] <= cpu_dout;

        // Map read data one clk after the address
        if (rd_pend) begin
            read_checks = read_checks + 1;
            if (map_dout !== rd_exp) begin
                err_count = err_count + 1;
                $display("** Error @ %0t: map read expected %h got %h", $time, rd_exp, map_dout);
            end
        end
        rd_pend <= !rst && map_cs && cpu_rnw;
        rd_exp  <= map_ref[cpu_addr];

        // Pixel registered on the previous edge
        if (px_pend) begin
            pxl_checks = pxl_checks + 1;
            if (pxl !== px_exp) begin
                err_count = err_count + 1;
                $display("** Error @ %0t: pixel at hdump %0d expected %h got %h",
                         $time, px_col, px_exp, pxl);
            end
        end
        px_pend <= !rst && pxl_cen && hdump >= WARMUP;
        px_exp  <= expected_pixel(hdump, hpos, vdump, flip);
        px_col  <= hdump;
    end

endmodule

/* scroll_fetch_ctrl.sv */
// Scroll fetch sequencer
// Works out the scrolled and optionally flipped beam position,
// reads the tile map one tile ahead, builds the graphics ROM
// address and strobes the row load into the pixel shifter.
// Phases come from the low three bits of the effective column.
module scroll_fetch_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,

    // Beam and scroll
    input  scroll_pkg::hpos_t      hpos,
    input  scroll_pkg::hpos_t      hdump,
    input  scroll_pkg::vpos_t      vdump,
    input  logic                   flip,

    // Tile map video port
    output scroll_pkg::map_addr_t  map_addr,
    input  scroll_pkg::byte_t      code,
    input  scroll_pkg::byte_t      attr,

    // Graphics ROM and shifter
    output scroll_pkg::rom_addr_t  rom_addr,
    output logic                   row_load,
    output scroll_pkg::tile_attr_t tile_attr
);

    typedef logic [2:0] phase_t;

    localparam phase_t PH_ROM  = 3'd0; // Set the ROM address from code and attribute
    localparam phase_t PH_LOAD = 3'd4; // Hand the ROM row to the shifter
    localparam phase_t PH_MAP  = 3'd7; // Read the tile map on the last pixel of a tile

    scroll_pkg::hpos_t      hsum;
    scroll_pkg::hpos_t      heff;      // Effective column
    scroll_pkg::vpos_t      veff;      // Effective row
    scroll_pkg::tile_attr_t attr_in;
    phase_t                 phase;
    logic [2:0]             row_sel;   // Pixel row inside the tile

    always_comb begin
        hsum    = hdump + hpos + scroll_pkg::FETCH_LEAD;
        heff    = hsum ^ {1'b0, {8{flip}}};    // Bit 8 keeps the page
        veff    = vdump ^ {8{flip}};
        attr_in = scroll_pkg::tile_attr_t'(attr);
        phase   = heff[2:0];
        row_sel = veff[2:0] ^ {3{attr_in.vflip}};
    end

    // Tile map index from the top 5 bits of veff and heff[8:3]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_addr <= '0;
        end else if (pxl_cen && phase == PH_MAP) begin
            map_addr <= {veff[7:3], heff[8:3]};
        end
    end

    // ROM address and attribute of the tile in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_addr  <= '0;
            tile_attr <= '0;
        end else if (pxl_cen && phase == PH_ROM) begin
            rom_addr  <= {attr_in.code_hi, code, row_sel};  // 2+8+3
            tile_attr <= attr_in;
            tile_attr.hflip <= attr_in.hflip ^ flip;        // Screen flip mirrors each tile too
        end
    end

    // One clk wide on the phase-4 pixel
    assign row_load = pxl_cen && phase == PH_LOAD;

    // The ROM address holds still across the load
    a_load_window: assert property (
        @(posedge clk) disable iff (rst)
        $rose(row_load) |-> $stable(rom_addr)
    ) else $error("row load outside its fetch window");

endmodule

/* scroll_layer.sv */
// Scroll layer top level
// One tile-map scroll plane: CPU-visible tile map, fetch sequencer
// ahead of the beam, pixel shifter and palette PROM. The graphics
// ROM sits outside and answers within the fetch window.
module scroll_layer #(
    parameter int MAP_AW = 11          // Tile map index width
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,

    // CPU port
    input  scroll_pkg::cpu_addr_t cpu_addr,
    input  scroll_pkg::byte_t     cpu_dout,
    input  logic                  cpu_rnw,
    input  logic                  map_cs,
    output scroll_pkg::byte_t     map_dout,

    // Beam and scroll
    input  scroll_pkg::hpos_t     hpos,
    input  scroll_pkg::hpos_t     hdump,
    input  scroll_pkg::vpos_t     vdump,
    input  logic                  flip,

    // Palette programming
    input  logic                  prog_en,
    input  scroll_pkg::pal_addr_t prog_addr,
    input  scroll_pkg::nibble_t   prog_data,

    // Graphics ROM
    output scroll_pkg::rom_addr_t rom_addr,
    input  scroll_pkg::rom_row_t  rom_data,

    output scroll_pkg::nibble_t   pxl
);

    scroll_pkg::map_addr_t  map_addr;
    scroll_pkg::byte_t      code;
    scroll_pkg::byte_t      attr;
    logic                   row_load;
    scroll_pkg::tile_attr_t tile_attr;
    scroll_pkg::pal_addr_t  pal_addr;

    scroll_tilemap #(
        .MAP_AW    (MAP_AW)
    ) tilemap_i (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .map_cs    (map_cs),
        .map_dout  (map_dout),
        .map_addr  (map_addr),
        .code      (code),
        .attr      (attr)
    );

    scroll_fetch_ctrl fetch_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hpos      (hpos),
        .hdump     (hdump),
        .vdump     (vdump),
        .flip      (flip),
        .map_addr  (map_addr),
        .code      (code),
        .attr      (attr),
        .rom_addr  (rom_addr),
        .row_load  (row_load),
        .tile_attr (tile_attr)
    );

    scroll_pixel_shifter shifter_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .row_load  (row_load),
        .rom_data  (rom_data),
        .tile_attr (tile_attr),
        .pal_addr  (pal_addr)
    );

    scroll_palette palette_i (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pal_addr  (pal_addr),
        .pxl       (pxl)
    );

endmodule

/* scroll_palette.sv */
// Scroll palette PROM
// 256 entries of 4 bits, indexed by palette bank and pixel.
// Loadable through the programming port, looked up once per pixel
// with a registered output.
module scroll_palette (
    input  logic                  clk,
    input  logic                  pxl_cen,

    // Programming port
    input  logic                  prog_en,
    input  scroll_pkg::pal_addr_t prog_addr,
    input  scroll_pkg::nibble_t   prog_data,

    // Lookup
    input  scroll_pkg::pal_addr_t pal_addr,
    output scroll_pkg::nibble_t   pxl
);

    scroll_pkg::nibble_t mem [256];

    // Blank colours until the PROM is loaded
    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = '0;
        pxl = '0;
    end

    always @(posedge clk) begin
        if (prog_en)
            mem[prog_addr] <= prog_data;
        if (pxl_cen)
            pxl <= mem[pal_addr];              // One pixel of latency
    end

endmodule

/* scroll_pixel_shifter.sv */
// Scroll pixel shifter
// Holds the fetched ROM row of eight pixels and moves one nibble
// out per pixel, leftwards normally and rightwards for a mirrored
// tile. Presents the palette bank with the leading nibble.
module scroll_pixel_shifter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,

    input  logic                   row_load,
    input  scroll_pkg::rom_row_t   rom_data,
    input  scroll_pkg::tile_attr_t tile_attr,

    output scroll_pkg::pal_addr_t  pal_addr
);

    scroll_pkg::rom_row_t row;
    logic                 cur_hf;      // Direction of the tile on screen
    scroll_pkg::nibble_t  cur_pal;
    scroll_pkg::nibble_t  lead_pxl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row     <= '0;
            cur_hf  <= 1'b0;
            cur_pal <= '0;
        end else if (pxl_cen) begin
            if (row_load) begin
                row     <= rom_data;
                cur_hf  <= tile_attr.hflip;
                cur_pal <= tile_attr.pal;
            end else if (cur_hf) begin
                row <= row >> 4;               // Mirrored, right end first
            end else begin
                row <= row << 4;
            end
        end
    end

    // Leading pixel sits at the end the row leaves from
    assign lead_pxl = cur_hf ? row[3:0] : row[31:28];
    assign pal_addr = {cur_pal, lead_pxl};

endmodule

/* scroll_pkg.sv */
// Scroll layer shared definitions
// Widths of the tile map, graphics ROM and palette paths,
// plus the unpacked form of the tile attribute byte
package scroll_pkg;

    // CPU side of the tile map
    typedef logic [11:0] cpu_addr_t;   // Bit 11 picks the attribute bank
    typedef logic [7:0]  byte_t;       // CPU data, tile code, raw attribute

    // Video side
    typedef logic [10:0] map_addr_t;   // Row 5 bits, column 6 bits
    typedef logic [8:0]  hpos_t;       // Horizontal position or scroll
    typedef logic [7:0]  vpos_t;       // Vertical position

    // Graphics ROM
    typedef logic [12:0] rom_addr_t;   // Code high 2, code 8, row 3
    typedef logic [31:0] rom_row_t;    // Eight 4-bit pixels, leftmost in 31:28

    // Pixel and colour
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  pal_addr_t;   // Palette bank 4, pixel 4

    // Attribute byte as stored in the upper bank
    typedef struct packed {
        logic [1:0] code_hi;           // Extends the tile code to 10 bits
        logic       hflip;
        logic       vflip;
        logic [3:0] pal;               // Palette bank
    } tile_attr_t;

    // Pixels by which the map fetch runs ahead of the beam
    localparam hpos_t FETCH_LEAD = 9'd8;

endpackage

/* scroll_tb.sv */
// Scroll layer testbench
// Loads a random graphics ROM, tile map and palette, checks CPU map
// access, then runs scanlines with random scroll and row, first with
// the screen upright and then flipped, while the checker compares pixels
module scroll_tb;

    localparam int NUM_LINES = 6;            // Per flip setting
    localparam int ROM_WORDS = 8192;
    localparam int MAP_BYTES = 4096;         // Both banks
    localparam int CPU_OPS   = 800;          // Mixed writes and reads
    localparam int PAL_WORDS = 256;
    localparam int LINE_CLKS = 512 * 2;      // pxl_cen on every second clk
    localparam int TEST_CLKS = ROM_WORDS + MAP_BYTES + 2 * CPU_OPS + PAL_WORDS
                             + 2 * NUM_LINES * LINE_CLKS;
    localparam int WATCHDOG  = (TEST_CLKS + 1000) * 4;

    logic                  clk;
    logic                  rst;
    logic                  pxl_cen;
    scroll_pkg::cpu_addr_t cpu_addr;
    scroll_pkg::byte_t     cpu_dout;
    logic                  cpu_rnw;
    logic                  map_cs;
    scroll_pkg::byte_t     map_dout;
    scroll_pkg::hpos_t     hpos;
    scroll_pkg::hpos_t     hdump;
    scroll_pkg::vpos_t     vdump;
    logic                  flip;
    logic                  prog_en;
    scroll_pkg::pal_addr_t prog_addr;
    scroll_pkg::nibble_t   prog_data;
    scroll_pkg::rom_addr_t rom_addr;
    scroll_pkg::rom_row_t  rom_data;
    scroll_pkg::nibble_t   pxl;

    logic                  rom_fill_en;
    scroll_pkg::rom_addr_t rom_fill_addr;
    scroll_pkg::rom_row_t  rom_fill_data;
    scroll_pkg::rom_row_t  rom_mem [ROM_WORDS];

    int                    err_count;
    int                    read_checks;
    int                    pxl_checks;
    logic [31:0]           rng = 32'hddef7d28;
    scroll_pkg::hpos_t     line_hpos [NUM_LINES];
    scroll_pkg::vpos_t     line_vdump [NUM_LINES];

    scroll_layer #(
        .MAP_AW    (11)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .map_cs    (map_cs),
        .map_dout  (map_dout),
        .hpos      (hpos),
        .hdump     (hdump),
        .vdump     (vdump),
        .flip      (flip),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pxl       (pxl)
    );

    scroll_checker chk_i (
        .clk           (clk),
        .rst           (rst),
        .pxl_cen       (pxl_cen),
        .cpu_addr      (cpu_addr),
        .cpu_dout      (cpu_dout),
        .cpu_rnw       (cpu_rnw),
        .map_cs        (map_cs),
        .map_dout      (map_dout),
        .hpos          (hpos),
        .hdump         (hdump),
        .vdump         (vdump),
        .flip          (flip),
        .prog_en       (prog_en),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .rom_fill_en   (rom_fill_en),
        .rom_fill_addr (rom_fill_addr),
        .rom_fill_data (rom_fill_data),
        .pxl           (pxl),
        .err_count     (err_count),
        .read_checks   (read_checks),
        .pxl_checks    (pxl_checks)
    );

    always #2 clk = ~clk;

    // Graphics ROM model, one clk of latency, well inside the fetch window
    always @(posedge clk) begin
        if (rom_fill_en)
            rom_mem[rom_fill_addr] <= rom_fill_data;
        rom_data <= rom_mem[rom_addr];
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic load_rom();
        logic [31:0] r;
        for (int a = 0; a < ROM_WORDS; a++) begin
            next_random(r);
            @(posedge clk);
            rom_fill_en   <= 1'b1;
            rom_fill_addr <= scroll_pkg::rom_addr_t'(a);
            rom_fill_data <= r;
        end
        @(posedge clk);
        rom_fill_en <= 1'b0;
    endtask

    task automatic write_map(input scroll_pkg::cpu_addr_t a, input scroll_pkg::byte_t d);
        @(posedge clk);
        map_cs   <= 1'b1;
        cpu_rnw  <= 1'b0;
        cpu_addr <= a;
        cpu_dout <= d;
    endtask

    task automatic read_map(input scroll_pkg::cpu_addr_t a);
        @(posedge clk);
        map_cs   <= 1'b1;
        cpu_rnw  <= 1'b1;
        cpu_addr <= a;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        map_cs  <= 1'b0;
        cpu_rnw <= 1'b1;
    endtask

    // Every entry of both banks gets a random byte
    task automatic seed_map();
        logic [31:0] r;
        for (int a = 0; a < MAP_BYTES; a++) begin
            next_random(r);
            write_map(scroll_pkg::cpu_addr_t'(a), r[7:0]);
        end
        bus_idle();
    endtask

    task automatic mix_cpu_access();
        logic [31:0] r;
        for (int n = 0; n < CPU_OPS; n++) begin
            next_random(r);
            if (r[31]) begin
                read_map(r[11:0]);
            end else begin
                write_map(r[11:0], r[19:12]);
                if (r[30])
                    read_map(r[11:0]);     // Read straight after the write
            end
        end
        bus_idle();
    endtask

    task automatic program_palette();
        logic [31:0] r;
        for (int a = 0; a < PAL_WORDS; a++) begin
            next_random(r);
            @(posedge clk);
            prog_en   <= 1'b1;
            prog_addr <= scroll_pkg::pal_addr_t'(a);
            prog_data <= r[3:0];
        end
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    // One 512-pixel line, scroll, row and flip change with hdump at 0
    task automatic run_line(
        input scroll_pkg::hpos_t h,
        input scroll_pkg::vpos_t v,
        input logic              f
    );
        for (int i = 0; i < 512; i++) begin
            @(posedge clk);
            pxl_cen <= 1'b1;
            hdump   <= scroll_pkg::hpos_t'(i);
            if (i == 0) begin
                hpos  <= h;
                vdump <= v;
                flip  <= f;
            end
            @(posedge clk);
            pxl_cen <= 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        clk           = 1'b0;
        rst           = 1'b1;
        pxl_cen       = 1'b0;
        cpu_addr      = '0;
        cpu_dout      = '0;
        cpu_rnw       = 1'b1;
        map_cs        = 1'b0;
        hpos          = '0;
        hdump         = '0;
        vdump         = '0;
        flip          = 1'b0;
        prog_en       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        rom_data      = '0;
        rom_fill_en   = 1'b0;
        rom_fill_addr = '0;
        rom_fill_data = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        load_rom();
        seed_map();
        mix_cpu_access();
        program_palette();

        for (int i = 0; i < NUM_LINES; i++) begin
            next_random(r);
            line_hpos[i]  = r[8:0];
            line_vdump[i] = r[16:9];
        end
        // Upright pass, then the same lines flipped
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < NUM_LINES; i++)
                run_line(line_hpos[i], line_vdump[i], f[0]);
        end
        repeat (4) @(posedge clk);

        $display("Checks: %0d map reads, %0d pixels, %0d errors",
                 read_checks, pxl_checks, err_count);
        if (err_count == 0 && read_checks > 0 && pxl_checks > 0) begin
            $display("sim passed");
        end else begin
            if (read_checks == 0 || pxl_checks == 0)
                $display("Some checks never ran");
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* scroll_tilemap.sv */
// Scroll tile map RAM
// Two byte banks, tile code and tile attribute, sharing one index.
// The CPU port writes and reads one bank picked by the top address
// bit; the video port reads both banks together so a tile arrives whole.
module scroll_tilemap #(
    parameter int MAP_AW = 11          // Entries per bank as a power of two
) (
    input  logic                  clk,

    // CPU port
    input  scroll_pkg::cpu_addr_t cpu_addr,
    input  scroll_pkg::byte_t     cpu_dout,
    input  logic                  cpu_rnw,
    input  logic                  map_cs,
    output scroll_pkg::byte_t     map_dout,

    // Video port
    input  scroll_pkg::map_addr_t map_addr,
    output scroll_pkg::byte_t     code,
    output scroll_pkg::byte_t     attr
);

    scroll_pkg::byte_t  code_mem [2**MAP_AW];
    scroll_pkg::byte_t  attr_mem [2**MAP_AW];

    logic [MAP_AW-1:0]  cpu_idx;
    logic               cpu_we;
    scroll_pkg::byte_t  cpu_code;      // CPU read of each bank
    scroll_pkg::byte_t  cpu_attr;
    logic               bank_q;        // Bank select, aligned to read data

    assign cpu_idx = cpu_addr[MAP_AW-1:0];
    assign cpu_we  = map_cs & ~cpu_rnw;

    // CPU side, write first bank decode then registered read
    always_ff @(posedge clk) begin
        if (cpu_we && !cpu_addr[MAP_AW])
            code_mem[cpu_idx] <= cpu_dout;
        if (cpu_we && cpu_addr[MAP_AW])
            attr_mem[cpu_idx] <= cpu_dout;
        cpu_code <= code_mem[cpu_idx]; // Old data on a same-cycle write
        cpu_attr <= attr_mem[cpu_idx];
        bank_q   <= cpu_addr[MAP_AW];
    end

    assign map_dout = bank_q ? cpu_attr : cpu_code;

    // Video side, read only
    always_ff @(posedge clk) begin
        code <= code_mem[map_addr[MAP_AW-1:0]];
        attr <= attr_mem[map_addr[MAP_AW-1:0]];
    end

    // Once the sequencer has driven a clean index it never goes unknown again
    a_map_addr_known: assert property (
        @(posedge clk) !$isunknown($past(map_addr)) |-> !$isunknown(map_addr)
    ) else $error("tile map video address went unknown");

endmodule

/* vlog.f */
scroll_pkg.sv
scroll_tilemap.sv
scroll_fetch_ctrl.sv
scroll_pixel_shifter.sv
scroll_palette.sv
scroll_layer.sv
scroll_checker.sv
scroll_tb.sv
